// ==== common/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

	localparam int word_w = 32;
	localparam int reg_addr_w = 5;

	localparam int imem_words = 64;
	localparam int dmem_words = 64;
	localparam int mem_index_w = 6; // Word index, address bits 7:2

	// Instruction field positions
	localparam int op_msb = 31;
	localparam int op_lsb = 26;
	localparam int rs_msb = 25;
	localparam int rs_lsb = 21;
	localparam int rt_msb = 20;
	localparam int rt_lsb = 16;
	localparam int rd_msb = 15;
	localparam int rd_lsb = 11;
	localparam int shamt_msb = 10;
	localparam int shamt_lsb = 6;
	localparam int funct_msb = 5;
	localparam int funct_lsb = 0;
	localparam int imm_msb = 15;
	localparam int imm_lsb = 0;

	typedef enum logic [5:0] {
		op_rtype = 6'b000000,
		op_addiu = 6'b001001,
		op_slti  = 6'b001010,
		op_ori   = 6'b001101,
		op_xori  = 6'b001110,
		op_lui   = 6'b001111,
		op_lw    = 6'b100011,
		op_sw    = 6'b101011
	} op_e;

	// ADD and SUB never trap here, decode treats them as ADDU and SUBU
	typedef enum logic [5:0] {
		fn_sll  = 6'b000000,
		fn_srl  = 6'b000010,
		fn_sra  = 6'b000011,
		fn_add  = 6'b100000,
		fn_addu = 6'b100001,
		fn_sub  = 6'b100010,
		fn_subu = 6'b100011,
		fn_and  = 6'b100100,
		fn_or   = 6'b100101,
		fn_xor  = 6'b100110,
		fn_nor  = 6'b100111,
		fn_slt  = 6'b101010,
		fn_sltu = 6'b101011
	} funct_e;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
		alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui
	} alu_op_e;

endpackage

`default_nettype wire

// ==== decode/register_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module register_file (
	input  wire                                clock,
	input  wire                                rst,
	input  wire  [mips_pkg::reg_addr_w-1:0]   rs,
	input  wire  [mips_pkg::reg_addr_w-1:0]   rt,
	input  wire                                we,
	input  wire  [mips_pkg::reg_addr_w-1:0]   rd,
	input  wire  [mips_pkg::word_w-1:0]        wd,
	output logic [mips_pkg::word_w-1:0]        rs_data,
	output logic [mips_pkg::word_w-1:0]        rt_data
);

	logic [mips_pkg::word_w-1:0] regs [2**mips_pkg::reg_addr_w];

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < 2**mips_pkg::reg_addr_w; i++)
				regs[i] <= '0;
		end else if (we && rd != '0) begin
			regs[rd] <= wd;
		end
	end

	// Writeback in the same cycle is passed straight through
	always_comb begin
		if (rs == '0)
			rs_data = '0;
		else if (we && rd == rs)
			rs_data = wd;
		else
			rs_data = regs[rs];
		if (rt == '0)
			rt_data = '0;
		else if (we && rd == rt)
			rt_data = wd;
		else
			rt_data = regs[rt];
	end

endmodule

`default_nettype wire

// ==== decode/decode_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
	input  wire                                clock,
	input  wire                                rst,
	input  wire                                f_valid,
	input  wire  [mips_pkg::word_w-1:0]        f_pc,
	input  wire  [mips_pkg::word_w-1:0]        f_insn,
	input  wire                                wb_we,
	input  wire  [mips_pkg::reg_addr_w-1:0]   wb_rd,
	input  wire  [mips_pkg::word_w-1:0]        wb_data,
	output logic                               stall,
	output logic                               d_valid,
	output logic [mips_pkg::word_w-1:0]        d_pc,
	output mips_pkg::alu_op_e                  d_alu_op,
	output logic [mips_pkg::word_w-1:0]        d_a,
	output logic [mips_pkg::word_w-1:0]        d_b,
	output logic [mips_pkg::shamt_msb-mips_pkg::shamt_lsb:0] d_shamt,
	output logic [mips_pkg::reg_addr_w-1:0]    d_rd,
	output logic                               d_reg_we,
	output logic                               d_mem_read,
	output logic                               d_mem_write,
	output logic [mips_pkg::word_w-1:0]        d_store_data
);

	mips_pkg::op_e opcode;
	mips_pkg::funct_e funct;
	mips_pkg::alu_op_e alu_op;
	logic [mips_pkg::reg_addr_w-1:0] rs_f, rt_f, rd_f, dest;
	logic [mips_pkg::imm_msb:mips_pkg::imm_lsb] imm;
	logic [mips_pkg::word_w-1:0] imm_sx, imm_zx, rs_data, rt_data, operand_b;
	logic legal, mem_read, mem_write, reg_we;
	logic ex_busy, mem_busy;
	logic [mips_pkg::reg_addr_w-1:0] mem_rd; // Destination now in the memory register

	assign opcode = mips_pkg::op_e'(f_insn[mips_pkg::op_msb:mips_pkg::op_lsb]);
	assign funct = mips_pkg::funct_e'(f_insn[mips_pkg::funct_msb:mips_pkg::funct_lsb]);
	assign rs_f = f_insn[mips_pkg::rs_msb:mips_pkg::rs_lsb];
	assign rt_f = f_insn[mips_pkg::rt_msb:mips_pkg::rt_lsb];
	assign rd_f = f_insn[mips_pkg::rd_msb:mips_pkg::rd_lsb];
	assign imm = f_insn[mips_pkg::imm_msb:mips_pkg::imm_lsb];
	assign imm_sx = {{(mips_pkg::word_w-mips_pkg::imm_msb-1){imm[mips_pkg::imm_msb]}}, imm};
	assign imm_zx = {{(mips_pkg::word_w-mips_pkg::imm_msb-1){1'b0}}, imm};

	register_file regs_i (
		.clock   (clock),
		.rst     (rst),
		.rs      (rs_f),
		.rt      (rt_f),
		.we      (wb_we),
		.rd      (wb_rd),
		.wd      (wb_data),
		.rs_data (rs_data),
		.rt_data (rt_data)
	);

	always_comb begin
		legal = 1'b1;
		alu_op = mips_pkg::alu_add;
		operand_b = rt_data;
		dest = rt_f; // I-type writes rt
		mem_read = 1'b0;
		mem_write = 1'b0;
		case (opcode)
			mips_pkg::op_rtype: begin
				dest = rd_f;
				case (funct)
					mips_pkg::fn_add, mips_pkg::fn_addu: alu_op = mips_pkg::alu_add;
					mips_pkg::fn_sub, mips_pkg::fn_subu: alu_op = mips_pkg::alu_sub;
					mips_pkg::fn_and:  alu_op = mips_pkg::alu_and;
					mips_pkg::fn_or:   alu_op = mips_pkg::alu_or;
					mips_pkg::fn_xor:  alu_op = mips_pkg::alu_xor;
					mips_pkg::fn_nor:  alu_op = mips_pkg::alu_nor;
					mips_pkg::fn_slt:  alu_op = mips_pkg::alu_slt;
					mips_pkg::fn_sltu: alu_op = mips_pkg::alu_sltu;
					mips_pkg::fn_sll:  alu_op = mips_pkg::alu_sll;
					mips_pkg::fn_srl:  alu_op = mips_pkg::alu_srl;
					mips_pkg::fn_sra:  alu_op = mips_pkg::alu_sra;
					default:           legal = 1'b0;
				endcase
			end
			mips_pkg::op_addiu: operand_b = imm_sx;
			mips_pkg::op_slti: begin
				alu_op = mips_pkg::alu_slt;
				operand_b = imm_sx;
			end
			mips_pkg::op_ori: begin
				alu_op = mips_pkg::alu_or;
				operand_b = imm_zx;
			end
			mips_pkg::op_xori: begin
				alu_op = mips_pkg::alu_xor;
				operand_b = imm_zx;
			end
			mips_pkg::op_lui: begin
				alu_op = mips_pkg::alu_lui;
				operand_b = imm_zx;
			end
			mips_pkg::op_lw: begin
				operand_b = imm_sx;
				mem_read = 1'b1;
			end
			mips_pkg::op_sw: begin
				operand_b = imm_sx;
				mem_write = 1'b1;
			end
			default: legal = 1'b0;
		endcase
	end

	assign reg_we = legal && !mem_write && dest != '0;

	// Read-after-write against the execute and memory registers
	assign ex_busy = d_valid && d_reg_we;
	assign stall = f_valid && (
		(rs_f != '0 && ((ex_busy && rs_f == d_rd) || (mem_busy && rs_f == mem_rd))) ||
		(rt_f != '0 && ((ex_busy && rt_f == d_rd) || (mem_busy && rt_f == mem_rd))));

	always_ff @(posedge clock) begin
		if (rst) begin
			d_valid <= 1'b0;
			d_reg_we <= 1'b0;
			d_mem_read <= 1'b0;
			d_mem_write <= 1'b0;
			mem_busy <= 1'b0;
		end else begin
			d_valid <= f_valid && legal && !stall; // Bubble on stall
			d_reg_we <= reg_we;
			d_mem_read <= mem_read;
			d_mem_write <= mem_write;
			mem_busy <= ex_busy;
		end
	end

	always_ff @(posedge clock) begin
		d_pc <= f_pc;
		d_alu_op <= alu_op;
		d_a <= rs_data;
		d_b <= operand_b;
		d_shamt <= f_insn[mips_pkg::shamt_msb:mips_pkg::shamt_lsb];
		d_rd <= dest;
		d_store_data <= rt_data;
		mem_rd <= d_rd;
	end

endmodule

`default_nettype wire

// ==== execute/execute_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
	input  wire                                clock,
	input  wire                                rst,
	input  wire                                d_valid,
	input  wire  [mips_pkg::word_w-1:0]        d_pc,
	input  mips_pkg::alu_op_e                  d_alu_op,
	input  wire  [mips_pkg::word_w-1:0]        d_a,
	input  wire  [mips_pkg::word_w-1:0]        d_b,
	input  wire  [mips_pkg::shamt_msb-mips_pkg::shamt_lsb:0] d_shamt,
	input  wire  [mips_pkg::reg_addr_w-1:0]   d_rd,
	input  wire                                d_reg_we,
	input  wire                                d_mem_read,
	input  wire                                d_mem_write,
	input  wire  [mips_pkg::word_w-1:0]        d_store_data,
	output logic                               x_valid,
	output logic [mips_pkg::word_w-1:0]        x_pc,
	output logic [mips_pkg::word_w-1:0]        x_result,
	output logic [mips_pkg::reg_addr_w-1:0]    x_rd,
	output logic                               x_reg_we,
	output logic                               x_mem_read,
	output logic                               x_mem_write,
	output logic [mips_pkg::word_w-1:0]        x_store_data
);

	logic [mips_pkg::word_w-1:0] result;

	// Loads and stores take the add path for their address
	always_comb begin
		case (d_alu_op)
			mips_pkg::alu_add:  result = d_a + d_b;
			mips_pkg::alu_sub:  result = d_a - d_b;
			mips_pkg::alu_and:  result = d_a & d_b;
			mips_pkg::alu_or:   result = d_a | d_b;
			mips_pkg::alu_xor:  result = d_a ^ d_b;
			mips_pkg::alu_nor:  result = ~(d_a | d_b);
			mips_pkg::alu_slt:  result = {{(mips_pkg::word_w-1){1'b0}}, $signed(d_a) < $signed(d_b)};
			mips_pkg::alu_sltu: result = {{(mips_pkg::word_w-1){1'b0}}, d_a < d_b};
			mips_pkg::alu_sll:  result = d_b << d_shamt;
			mips_pkg::alu_srl:  result = d_b >> d_shamt;
			mips_pkg::alu_sra:  result = $signed(d_b) >>> d_shamt; // Sign fill
			mips_pkg::alu_lui:  result = d_b << 16;
			default:            result = d_a + d_b;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			x_valid <= 1'b0;
			x_reg_we <= 1'b0;
			x_mem_read <= 1'b0;
			x_mem_write <= 1'b0;
		end else begin
			x_valid <= d_valid;
			x_reg_we <= d_reg_we;
			x_mem_read <= d_mem_read;
			x_mem_write <= d_mem_write;
		end
	end

	always_ff @(posedge clock) begin
		x_pc <= d_pc;
		x_result <= result;
		x_rd <= d_rd;
		x_store_data <= d_store_data;
	end

endmodule

`default_nettype wire

// ==== hw/fetch_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
	input  wire                                clock,
	input  wire                                rst,
	input  wire                                run,
	input  wire                                stall,
	input  wire                                load_we,
	input  wire  [mips_pkg::mem_index_w-1:0]  load_addr,
	input  wire  [mips_pkg::word_w-1:0]        load_data,
	output logic                               f_valid,
	output logic [mips_pkg::word_w-1:0]        f_pc,
	output logic [mips_pkg::word_w-1:0]        f_insn
);

	logic [mips_pkg::word_w-1:0] imem [mips_pkg::imem_words];
	logic [mips_pkg::word_w-1:0] pc;
	logic [mips_pkg::mem_index_w-1:0] pc_index;
	logic advance;

	assign pc_index = pc[mips_pkg::mem_index_w+1:2]; // Wraps at 64 words
	assign advance = run && !stall;

	always_ff @(posedge clock) begin
		if (rst) begin
			pc <= '0;
			f_valid <= 1'b0;
		end else if (!stall) begin
			f_valid <= run;
			if (run)
				pc <= pc + 4;
		end
	end

	// Synchronous read, the output register is the fetch register
	always_ff @(posedge clock) begin
		if (load_we)
			imem[load_addr] <= load_data;
		if (advance) begin
			f_insn <= imem[pc_index];
			f_pc <= pc;
		end
	end

endmodule

`default_nettype wire

// ==== hw/memory_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module memory_stage (
	input  wire                                clock,
	input  wire                                rst,
	input  wire                                x_valid,
	input  wire  [mips_pkg::word_w-1:0]        x_pc,
	input  wire  [mips_pkg::word_w-1:0]        x_result,
	input  wire  [mips_pkg::reg_addr_w-1:0]   x_rd,
	input  wire                                x_reg_we,
	input  wire                                x_mem_read,
	input  wire                                x_mem_write,
	input  wire  [mips_pkg::word_w-1:0]        x_store_data,
	input  wire                                load_we,
	input  wire  [mips_pkg::mem_index_w-1:0]  load_addr,
	input  wire  [mips_pkg::word_w-1:0]        load_data,
	output logic                               retire_valid,
	output logic [mips_pkg::word_w-1:0]        retire_pc,
	output logic [mips_pkg::reg_addr_w-1:0]    retire_rd,
	output logic [mips_pkg::word_w-1:0]        retire_data
);

	logic [mips_pkg::word_w-1:0] dmem [mips_pkg::dmem_words];
	logic [mips_pkg::mem_index_w-1:0] index;
	logic [mips_pkg::word_w-1:0] load_word;
	logic [mips_pkg::word_w-1:0] wb_result;
	logic wb_load;

	assign index = x_result[mips_pkg::mem_index_w+1:2];

	always_ff @(posedge clock) begin
		if (load_we)
			dmem[load_addr] <= load_data; // Preload before run
		else if (x_valid && x_mem_write)
			dmem[index] <= x_store_data;
		if (x_valid && x_mem_read)
			load_word <= dmem[index];
		retire_pc <= x_pc;
		retire_rd <= x_rd;
		wb_result <= x_result;
		wb_load <= x_mem_read;
	end

	always_ff @(posedge clock) begin
		if (rst)
			retire_valid <= 1'b0;
		else
			retire_valid <= x_valid && x_reg_we;
	end

	assign retire_data = wb_load ? load_word : wb_result;

endmodule

`default_nettype wire

// ==== hw/mips_pipeline.sv ====
`timescale 1ns/1ns
`default_nettype none

module mips_pipeline (
	input  wire                                clock,
	input  wire                                rst,
	input  wire                                load_we,
	input  wire  [mips_pkg::mem_index_w-1:0]  load_addr,
	input  wire  [mips_pkg::word_w-1:0]        load_data,
	input  wire                                run,
	output logic                               retire_valid,
	output logic [mips_pkg::word_w-1:0]        retire_pc,
	output logic [mips_pkg::reg_addr_w-1:0]    retire_rd,
	output logic [mips_pkg::word_w-1:0]        retire_data
);

	logic stall;
	logic f_valid;
	logic [mips_pkg::word_w-1:0] f_pc, f_insn;

	logic d_valid, d_reg_we, d_mem_read, d_mem_write;
	logic [mips_pkg::word_w-1:0] d_pc, d_a, d_b, d_store_data;
	logic [mips_pkg::shamt_msb-mips_pkg::shamt_lsb:0] d_shamt;
	logic [mips_pkg::reg_addr_w-1:0] d_rd;
	mips_pkg::alu_op_e d_alu_op;

	logic x_valid, x_reg_we, x_mem_read, x_mem_write;
	logic [mips_pkg::word_w-1:0] x_pc, x_result, x_store_data;
	logic [mips_pkg::reg_addr_w-1:0] x_rd;

	fetch_stage fetch_i (
		.clock (clock), .rst (rst), .run (run), .stall (stall),
		.load_we (load_we), .load_addr (load_addr), .load_data (load_data),
		.f_valid (f_valid), .f_pc (f_pc), .f_insn (f_insn)
	);

	// Retire signals double as the register file write port
	decode_stage decode_i (
		.clock (clock), .rst (rst),
		.f_valid (f_valid), .f_pc (f_pc), .f_insn (f_insn),
		.wb_we (retire_valid), .wb_rd (retire_rd), .wb_data (retire_data),
		.stall (stall),
		.d_valid (d_valid), .d_pc (d_pc), .d_alu_op (d_alu_op),
		.d_a (d_a), .d_b (d_b), .d_shamt (d_shamt), .d_rd (d_rd),
		.d_reg_we (d_reg_we), .d_mem_read (d_mem_read), .d_mem_write (d_mem_write),
		.d_store_data (d_store_data)
	);

	execute_stage execute_i (
		.clock (clock), .rst (rst),
		.d_valid (d_valid), .d_pc (d_pc), .d_alu_op (d_alu_op),
		.d_a (d_a), .d_b (d_b), .d_shamt (d_shamt), .d_rd (d_rd),
		.d_reg_we (d_reg_we), .d_mem_read (d_mem_read), .d_mem_write (d_mem_write),
		.d_store_data (d_store_data),
		.x_valid (x_valid), .x_pc (x_pc), .x_result (x_result), .x_rd (x_rd),
		.x_reg_we (x_reg_we), .x_mem_read (x_mem_read), .x_mem_write (x_mem_write),
		.x_store_data (x_store_data)
	);

	memory_stage memory_i (
		.clock (clock), .rst (rst),
		.x_valid (x_valid), .x_pc (x_pc), .x_result (x_result), .x_rd (x_rd),
		.x_reg_we (x_reg_we), .x_mem_read (x_mem_read), .x_mem_write (x_mem_write),
		.x_store_data (x_store_data),
		.load_we (load_we), .load_addr (load_addr), .load_data (load_data),
		.retire_valid (retire_valid), .retire_pc (retire_pc),
		.retire_rd (retire_rd), .retire_data (retire_data)
	);

endmodule

`default_nettype wire

// ==== sim/clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module clock_gen (
	output logic clock,
	output logic rst
);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock; // 8 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (3) @(posedge clock);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== sim/pipeline_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipeline_assert (
	input wire                              clock,
	input wire                              rst,
	input wire                              run,
	input wire                              retire_valid,
	input wire [mips_pkg::reg_addr_w-1:0]  retire_rd
);

	logic ran; // Run seen high since reset

	always_ff @(posedge clock) begin
		if (rst)
			ran <= 1'b0;
		else if (run)
			ran <= 1'b1;
	end

	quiet_in_reset: assert property (@(posedge clock) rst |=> !retire_valid)
		else $error("retire_valid high in the cycle after a reset cycle");

	idle_before_run: assert property (@(posedge clock) disable iff (rst) !ran |-> !retire_valid)
		else $error("retire_valid high before run was ever raised");

	no_zero_retire: assert property (@(posedge clock) disable iff (rst)
		retire_valid |-> retire_rd != '0)
		else $error("retire reported for register zero");

endmodule

`default_nettype wire

// ==== sim/pipeline_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipeline_tb;

	localparam int prog_len = 48;
	localparam int mem_len = 64;
	localparam int timeout_cycles = 500; // 64 load cycles, 3 per instruction, margin

	logic clock, rst;
	logic load_we, run;
	logic [mips_pkg::mem_index_w-1:0] load_addr;
	logic [mips_pkg::word_w-1:0] load_data;
	logic retire_valid;
	logic [mips_pkg::word_w-1:0] retire_pc, retire_data;
	logic [mips_pkg::reg_addr_w-1:0] retire_rd;

	logic [31:0] prog [mem_len];
	logic [31:0] model_regs [32];
	logic [31:0] model_mem [mem_len];
	logic [31:0] exp_pc [$];
	logic [4:0] exp_rd [$];
	logic [31:0] exp_data [$];
	logic [31:0] rng_state;
	int n_expected, retire_count, error_count, cycle_count;

	clock_gen clock_i (.clock (clock), .rst (rst));

	mips_pipeline dut_i (
		.clock (clock), .rst (rst),
		.load_we (load_we), .load_addr (load_addr), .load_data (load_data),
		.run (run),
		.retire_valid (retire_valid), .retire_pc (retire_pc),
		.retire_rd (retire_rd), .retire_data (retire_data)
	);

	bind mips_pipeline pipeline_assert assert_i (
		.clock (clock), .rst (rst), .run (run),
		.retire_valid (retire_valid), .retire_rd (retire_rd)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] rtype(input logic [5:0] fn, input logic [4:0] rs, rt, rd, sh);
		return {6'b000000, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rs, rt,
			input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Two's complement compare from the sign bits
	function automatic logic signed_less(input logic [31:0] x, y);
		if (x[31] != y[31])
			return x[31]; // The negative one is smaller
		return x < y;
	endfunction

	task automatic build_program();
		logic [31:0] r;
		logic [4:0] rs, rt, rd, sh, prev;
		logic [15:0] mem_imm;
		int kind;
		prev = '0;
		for (int i = 0; i < prog_len; i++) begin
			rng_state = xorshift(rng_state);
			r = rng_state;
			kind = int'(r % 32'd20);
			rs = {2'b00, r[7:5]}; // Few registers, more hazards
			rt = {2'b00, r[10:8]};
			rd = {2'b00, r[13:11]};
			sh = r[20:16];
			mem_imm = {8'h00, r[23:18], 2'b00};
			// Runs of four dependent instructions, plus random ones
			if (((i % 12) >= 8 || r[15:14] == 2'b00) && prev != '0) begin
				rs = prev;
				if ((kind >= 8 && kind <= 10) || kind == 19)
					rt = prev; // Shifts and stores read rt
			end
			case (kind)
				0: prog[i] = rtype(mips_pkg::fn_addu, rs, rt, rd, sh);
				1: prog[i] = rtype(mips_pkg::fn_subu, rs, rt, rd, sh);
				2: prog[i] = rtype(mips_pkg::fn_and, rs, rt, rd, sh);
				3: prog[i] = rtype(mips_pkg::fn_or, rs, rt, rd, sh);
				4: prog[i] = rtype(mips_pkg::fn_xor, rs, rt, rd, sh);
				5: prog[i] = rtype(mips_pkg::fn_nor, rs, rt, rd, sh);
				6: prog[i] = rtype(mips_pkg::fn_slt, rs, rt, rd, sh);
				7: prog[i] = rtype(mips_pkg::fn_sltu, rs, rt, rd, sh);
				8: prog[i] = rtype(mips_pkg::fn_sll, rs, rt, rd, sh);
				9: prog[i] = rtype(mips_pkg::fn_srl, rs, rt, rd, sh);
				10: prog[i] = rtype(mips_pkg::fn_sra, rs, rt, rd, sh);
				11: prog[i] = rtype(mips_pkg::fn_add, rs, rt, rd, sh);
				12: prog[i] = rtype(mips_pkg::fn_sub, rs, rt, rd, sh);
				13: prog[i] = itype(mips_pkg::op_addiu, rs, rt, r[31:16]);
				14: prog[i] = itype(mips_pkg::op_slti, rs, rt, r[31:16]);
				15: prog[i] = itype(mips_pkg::op_ori, rs, rt, r[31:16]);
				16: prog[i] = itype(mips_pkg::op_xori, rs, rt, r[31:16]);
				17: prog[i] = itype(mips_pkg::op_lui, 5'd0, rt, r[31:16]);
				18: prog[i] = itype(mips_pkg::op_lw, 5'd0, rt, mem_imm);
				default: prog[i] = itype(mips_pkg::op_sw, 5'd0, rt, mem_imm);
			endcase
			if (kind <= 12 && rd != '0)
				prev = rd;
			else if (kind >= 13 && kind <= 18 && rt != '0)
				prev = rt;
		end
		for (int i = prog_len; i < mem_len; i++)
			prog[i] = '0; // NOP
	endtask

	task automatic run_model();
		mips_pkg::op_e op;
		mips_pkg::funct_e fn;
		logic [31:0] insn, a, b, simm, zimm, addr, val;
		logic [4:0] dest, sh;
		logic wr;
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		for (int i = 0; i < mem_len; i++)
			model_mem[i] = prog[i]; // Data memory starts as a copy of the program
		for (int i = 0; i < mem_len; i++) begin
			insn = prog[i];
			op = mips_pkg::op_e'(insn[31:26]);
			fn = mips_pkg::funct_e'(insn[5:0]);
			a = model_regs[insn[25:21]];
			b = model_regs[insn[20:16]];
			sh = insn[10:6];
			simm = {{16{insn[15]}}, insn[15:0]};
			zimm = {16'h0000, insn[15:0]};
			addr = a + simm;
			dest = insn[20:16];
			wr = 1'b1;
			val = '0;
			case (op)
				mips_pkg::op_rtype: begin
					dest = insn[15:11];
					case (fn)
						mips_pkg::fn_add, mips_pkg::fn_addu: val = a + b;
						mips_pkg::fn_sub, mips_pkg::fn_subu: val = a - b;
						mips_pkg::fn_and: val = a & b;
						mips_pkg::fn_or: val = a | b;
						mips_pkg::fn_xor: val = a ^ b;
						mips_pkg::fn_nor: val = ~(a | b);
						mips_pkg::fn_slt: val = {31'b0, signed_less(a, b)};
						mips_pkg::fn_sltu: val = {31'b0, a < b};
						mips_pkg::fn_sll: val = b << sh;
						mips_pkg::fn_srl: val = b >> sh;
						// Logical shift with the vacated top bits filled from bit 31
						mips_pkg::fn_sra: val = (b >> sh) | ({32{b[31]}} & ~(32'hffff_ffff >> sh));
						default: wr = 1'b0;
					endcase
				end
				mips_pkg::op_addiu: val = a + simm;
				mips_pkg::op_slti: val = {31'b0, signed_less(a, simm)};
				mips_pkg::op_ori: val = a | zimm;
				mips_pkg::op_xori: val = a ^ zimm;
				mips_pkg::op_lui: val = {insn[15:0], 16'h0000};
				mips_pkg::op_lw: val = model_mem[addr[7:2]];
				mips_pkg::op_sw: begin
					model_mem[addr[7:2]] = b;
					wr = 1'b0;
				end
				default: wr = 1'b0;
			endcase
			if (wr && dest != '0) begin
				model_regs[dest] = val;
				exp_pc.push_back(32'(i) << 2);
				exp_rd.push_back(dest);
				exp_data.push_back(val);
			end
		end
		n_expected = exp_pc.size();
	endtask

	always @(negedge clock) begin
		if (!rst && retire_valid) begin
			assert (retire_count < n_expected)
			else begin
				$display("Error: %0t ns unexpected retire at pc %h after all %0d expected writes",
					$time, retire_pc, n_expected);
				error_count++;
			end
			if (retire_count < n_expected) begin
				assert (retire_pc == exp_pc[retire_count] && retire_rd == exp_rd[retire_count]
					&& retire_data == exp_data[retire_count])
				else begin
					$display("Error: %0t ns retire %0d got %h %0d %h, expected %h %0d %h",
						$time, retire_count, retire_pc, retire_rd, retire_data,
						exp_pc[retire_count], exp_rd[retire_count], exp_data[retire_count]);
					error_count++;
				end
			end
			retire_count++;
		end
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count == timeout_cycles) begin
			$display("Timeout after %0d cycles with %0d of %0d retires seen",
				cycle_count, retire_count, n_expected);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		load_we = 1'b0;
		load_addr = '0;
		load_data = '0;
		run = 1'b0;
		retire_count = 0;
		error_count = 0;
		cycle_count = 0;
		n_expected = 0;
		rng_state = 32'd53;
		build_program();
		run_model();
		wait (!rst);
		@(posedge clock);
		for (int i = 0; i < mem_len; i++) begin
			load_we <= 1'b1;
			load_addr <= 6'(i);
			load_data <= prog[i];
			@(posedge clock);
		end
		load_we <= 1'b0;
		run <= 1'b1;
		// Stop fetching after the last write retires, long before the PC wraps
		while (retire_count < n_expected)
			@(posedge clock);
		run <= 1'b0;
		repeat (16) @(posedge clock);
		assert (retire_count == n_expected)
		else begin
			$display("Error: %0t ns saw %0d retires, model expects %0d",
				$time, retire_count, n_expected);
			error_count++;
		end
		$display("Errors: %0d, retires checked: %0d of %0d", error_count, retire_count, n_expected);
		if (error_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
common/mips_pkg.sv
decode/register_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
hw/fetch_stage.sv
hw/memory_stage.sv
hw/mips_pipeline.sv
sim/clock_gen.sv
sim/pipeline_assert.sv
sim/pipeline_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module pipeline_tb -o sim_pipeline
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/sim_pipeline)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST RESULT: PASS"; then
	exit 0
fi
exit 1
